//--- fpu_macros.svh
// Pipe widths and counts; assumes FLEN of 64 and a 32-bit instruction word
`ifndef FPU_MACROS_SVH
`define FPU_MACROS_SVH

// ------------------------------------------------------------
// Data path
// ------------------------------------------------------------
`define FPU_FLEN      64
`define FPU_NAN_BOX_S 64'hffff_ffff_7fc0_0000

// ------------------------------------------------------------
// Renaming and tracking
// ------------------------------------------------------------
`define FPU_RNID_W    6
`define FPU_TAG_W     5

// Write-back bus slots seen by the forwarding logic
`define FPU_WB_PORTS  3

// rs1 and rs2 only, no fused ops
`define FPU_SRC_NUM   2

`endif

//--- fpu_isa_pkg.sv
// Instruction-level encodings for the move and sign-injection ops; RV64 D encodings only
package fpu_isa_pkg;

  // Kept ops, anything else decodes to OP_ILLEGAL
  typedef enum logic [3:0] {
    OP_FMV_X_W  = 4'd0,
    OP_FMV_W_X  = 4'd1,
    OP_FMV_X_D  = 4'd2,
    OP_FMV_D_X  = 4'd3,
    OP_FSGNJ_S  = 4'd4,
    OP_FSGNJN_S = 4'd5,
    OP_FSGNJX_S = 4'd6,
    OP_FSGNJ_D  = 4'd7,
    OP_FSGNJN_D = 4'd8,
    OP_FSGNJX_D = 4'd9,
    OP_ILLEGAL  = 4'd15
  } fp_op_e;

  typedef enum logic {
    REG_GPR = 1'b0,
    REG_FPR = 1'b1
  } reg_type_e;

  // ------------------------------------------------------------
  // Major opcode and funct fields
  // ------------------------------------------------------------
  localparam logic [6:0] OPC_OP_FP  = 7'b101_0011;

  localparam logic [6:0] F7_FSGNJ_S = 7'h10;
  localparam logic [6:0] F7_FSGNJ_D = 7'h11;
  localparam logic [6:0] F7_FMV_X_W = 7'h70;
  localparam logic [6:0] F7_FMV_X_D = 7'h71;
  localparam logic [6:0] F7_FMV_W_X = 7'h78;
  localparam logic [6:0] F7_FMV_D_X = 7'h79;

  // funct3 picks the sign rule
  localparam logic [2:0] F3_SGNJ    = 3'b000;
  localparam logic [2:0] F3_SGNJN   = 3'b001;
  localparam logic [2:0] F3_SGNJX   = 3'b010;

  // Moves need funct3 and rs2 both zero
  localparam logic [2:0] F3_FMV     = 3'b000;
  localparam logic [4:0] RS2_FMV    = 5'd0;

endpackage

//--- fpu_pipe_pkg.sv
// Pipe-level types; the write-back bus is one slot per port, widths from the macros file
`include "fpu_macros.svh"

package fpu_pipe_pkg;
  import fpu_isa_pkg::*;

  // ------------------------------------------------------------
  // Single values
  // ------------------------------------------------------------
  typedef logic [`FPU_RNID_W-1:0] rnid_t;
  typedef logic [`FPU_FLEN-1:0]   data_t;
  typedef logic [`FPU_TAG_W-1:0]  tag_t;

  // ------------------------------------------------------------
  // Write-back bus, indexed by slot
  // ------------------------------------------------------------
  typedef logic [`FPU_WB_PORTS-1:0]      wb_valid_t;
  typedef reg_type_e [`FPU_WB_PORTS-1:0] wb_type_t;
  typedef rnid_t [`FPU_WB_PORTS-1:0]     wb_rnid_t;
  typedef data_t [`FPU_WB_PORTS-1:0]     wb_data_t;

endpackage

//--- fpu_issue_stage.sv
// Decode in ex0 and control through ex2; flush is a plain level and kills ex0 to ex2 at once
`include "fpu_macros.svh"

module fpu_issue_stage
  import fpu_isa_pkg::*;
  import fpu_pipe_pkg::*;
(
  input  logic                                i_clk,
  input  logic                                i_reset_n,
  input  logic                                i_issue_valid,
  input  logic [31:0]                         i_issue_inst,
  input  tag_t                                i_issue_tag,
  input  rnid_t                               i_rd_rnid,
  input  logic                                i_flush,
  output logic                                o_ex0_valid,
  output logic [`FPU_SRC_NUM-1:0]             o_ex0_src_use,
  output reg_type_e [`FPU_SRC_NUM-1:0]        o_ex0_src_type,
  output logic                                o_ex1_valid,
  output reg_type_e                           o_ex1_rd_type,
  output rnid_t                               o_ex1_rd_rnid,
  output logic                                o_ex2_valid,
  output fp_op_e                              o_ex2_op,
  output reg_type_e                           o_ex2_rd_type,
  output rnid_t                               o_ex2_rd_rnid,
  output tag_t                                o_ex2_tag
);

  logic [6:0] w_opcode;
  logic [6:0] w_funct7;
  logic [2:0] w_funct3;
  logic [4:0] w_rs2;
  fp_op_e     w_ex0_op;
  reg_type_e  w_ex0_rd_type;

  logic       r_ex1_valid;
  fp_op_e     r_ex1_op;
  tag_t       r_ex1_tag;
  logic       r_ex2_valid;

  // ------------------------------------------------------------
  // ex0 decode
  // ------------------------------------------------------------
  assign w_opcode = i_issue_inst[6:0];
  assign w_funct3 = i_issue_inst[14:12];
  assign w_rs2    = i_issue_inst[24:20];
  assign w_funct7 = i_issue_inst[31:25];

  always_comb begin
    w_ex0_op = OP_ILLEGAL;
    if (w_opcode == OPC_OP_FP) begin
      if ((w_funct7 == F7_FSGNJ_S) || (w_funct7 == F7_FSGNJ_D)) begin
        case (w_funct3)
          F3_SGNJ:  w_ex0_op = (w_funct7 == F7_FSGNJ_S) ? OP_FSGNJ_S : OP_FSGNJ_D;
          F3_SGNJN: w_ex0_op = (w_funct7 == F7_FSGNJ_S) ? OP_FSGNJN_S : OP_FSGNJN_D;
          F3_SGNJX: w_ex0_op = (w_funct7 == F7_FSGNJ_S) ? OP_FSGNJX_S : OP_FSGNJX_D;
          default:  w_ex0_op = OP_ILLEGAL;
        endcase
      end else if ((w_funct3 == F3_FMV) && (w_rs2 == RS2_FMV)) begin
        case (w_funct7)
          F7_FMV_X_W: w_ex0_op = OP_FMV_X_W;
          F7_FMV_X_D: w_ex0_op = OP_FMV_X_D;
          F7_FMV_W_X: w_ex0_op = OP_FMV_W_X;
          F7_FMV_D_X: w_ex0_op = OP_FMV_D_X;
          default:    w_ex0_op = OP_ILLEGAL;
        endcase
      end
    end
  end

  // Register types and source use per op
  always_comb begin
    o_ex0_src_use = '0;
    w_ex0_rd_type = REG_FPR;
    for (int s = 0; s < `FPU_SRC_NUM; s++) begin
      o_ex0_src_type[s] = REG_FPR;
    end
    case (w_ex0_op)
      OP_FMV_X_W, OP_FMV_X_D: begin
        o_ex0_src_use[0] = 1'b1;
        w_ex0_rd_type    = REG_GPR;
      end
      OP_FMV_W_X, OP_FMV_D_X: begin
        o_ex0_src_use[0]  = 1'b1;
        o_ex0_src_type[0] = REG_GPR;
      end
      OP_ILLEGAL: o_ex0_src_use = '0;
      default:    o_ex0_src_use[1:0] = 2'b11;
    endcase
  end

  assign o_ex0_valid = i_issue_valid & ~i_flush;

  // ------------------------------------------------------------
  // ex1 and ex2 registers
  // ------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_valid <= 1'b0;
      r_ex2_valid <= 1'b0;
    end else begin
      r_ex1_valid <= o_ex0_valid;
      r_ex2_valid <= r_ex1_valid & ~i_flush;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex1_op      <= w_ex0_op;
    r_ex1_tag     <= i_issue_tag;
    o_ex1_rd_type <= w_ex0_rd_type;
    o_ex1_rd_rnid <= i_rd_rnid;
    o_ex2_op      <= r_ex1_op;
    o_ex2_tag     <= r_ex1_tag;
    o_ex2_rd_type <= o_ex1_rd_type;
    o_ex2_rd_rnid <= o_ex1_rd_rnid;
  end

  // Early wakeup, an illegal op never writes
  assign o_ex1_valid = r_ex1_valid & ~i_flush & (r_ex1_op != OP_ILLEGAL);
  assign o_ex2_valid = r_ex2_valid & ~i_flush;

endmodule

//--- fpu_operand_lane.sv
// One source operand; register-file data returns one cycle after the ex0 request
`include "fpu_macros.svh"

module fpu_operand_lane
  import fpu_isa_pkg::*;
  import fpu_pipe_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset_n,
  input  logic      i_ex0_valid,
  input  logic      i_use,
  input  reg_type_e i_type,
  input  rnid_t     i_rnid,
  input  wb_valid_t i_wb_valid,
  input  wb_type_t  i_wb_type,
  input  wb_rnid_t  i_wb_rnid,
  input  wb_data_t  i_wb_data,
  input  data_t     i_rf_gpr_data,
  input  data_t     i_rf_fpr_data,
  output logic      o_rf_valid,
  output reg_type_e o_rf_type,
  output rnid_t     o_rf_rnid,
  output data_t     o_ex2_data
);

  wb_valid_t w_ex0_hit;
  wb_valid_t w_ex1_hit;
  wb_valid_t w_ex2_hit;
  data_t     w_ex1_rf_data;

  logic      r_ex1_use;
  logic      r_ex1_fwd;
  reg_type_e r_ex1_type;
  rnid_t     r_ex1_rnid;
  data_t     r_ex1_fwd_data;
  logic      r_ex2_use;
  reg_type_e r_ex2_type;
  rnid_t     r_ex2_rnid;
  data_t     r_ex2_data;

  // x0 is hardwired, no read and no forward
  function automatic logic is_zero_reg(input reg_type_e typ, input rnid_t rnid);
    return (typ == REG_GPR) && (rnid == '0);
  endfunction

  function automatic wb_valid_t match_bus(input logic use_src, input reg_type_e typ,
                                          input rnid_t rnid);
    wb_valid_t hit;
    for (int p = 0; p < `FPU_WB_PORTS; p++) begin
      hit[p] = use_src & i_wb_valid[p] & (i_wb_type[p] == typ) & (i_wb_rnid[p] == rnid) &
               ~is_zero_reg(typ, rnid);
    end
    return hit;
  endfunction

  // One-hot OR over the bus slots
  function automatic data_t pick_bus(input wb_valid_t hit);
    data_t sel;
    sel = '0;
    for (int p = 0; p < `FPU_WB_PORTS; p++) begin
      sel = sel | ({$bits(data_t){hit[p]}} & i_wb_data[p]);
    end
    return sel;
  endfunction

  // ------------------------------------------------------------
  // ex0 read request and first capture
  // ------------------------------------------------------------
  assign o_rf_valid = i_ex0_valid & i_use & ~is_zero_reg(i_type, i_rnid);
  assign o_rf_type  = i_type;
  assign o_rf_rnid  = i_rnid;
  assign w_ex0_hit  = match_bus(i_ex0_valid & i_use, i_type, i_rnid);

  // ------------------------------------------------------------
  // ex1 second capture, register-file data arrives
  // ------------------------------------------------------------
  assign w_ex1_hit = match_bus(r_ex1_use, r_ex1_type, r_ex1_rnid);

  always_comb begin
    if (r_ex1_type == REG_FPR) begin
      w_ex1_rf_data = i_rf_fpr_data;
    end else begin
      w_ex1_rf_data = is_zero_reg(r_ex1_type, r_ex1_rnid) ? '0 : i_rf_gpr_data;
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_use <= 1'b0;
      r_ex1_fwd <= 1'b0;
      r_ex2_use <= 1'b0;
    end else begin
      r_ex1_use <= i_ex0_valid & i_use;
      r_ex1_fwd <= |w_ex0_hit;
      r_ex2_use <= r_ex1_use;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex1_type     <= i_type;
    r_ex1_rnid     <= i_rnid;
    r_ex1_fwd_data <= pick_bus(w_ex0_hit);
    r_ex2_type     <= r_ex1_type;
    r_ex2_rnid     <= r_ex1_rnid;
    r_ex2_data     <= r_ex1_fwd    ? r_ex1_fwd_data :
                      |w_ex1_hit   ? pick_bus(w_ex1_hit) : w_ex1_rf_data;
  end

  // ------------------------------------------------------------
  // ex2 final select, the live bus wins
  // ------------------------------------------------------------
  assign w_ex2_hit  = match_bus(r_ex2_use, r_ex2_type, r_ex2_rnid);
  assign o_ex2_data = |w_ex2_hit ? pick_bus(w_ex2_hit) : r_ex2_data;

endmodule

//--- fpu_result_stage.sv
// Move and sign-injection compute in ex2, registered to ex3; an illegal op reports but never writes
`include "fpu_macros.svh"

module fpu_result_stage
  import fpu_isa_pkg::*;
  import fpu_pipe_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_reset_n,
  input  logic      i_ex2_valid,
  input  fp_op_e    i_ex2_op,
  input  reg_type_e i_ex2_rd_type,
  input  rnid_t     i_ex2_rd_rnid,
  input  tag_t      i_ex2_tag,
  input  data_t     i_rs1,
  input  data_t     i_rs2,
  output logic      o_wr_valid,
  output reg_type_e o_wr_type,
  output rnid_t     o_wr_rnid,
  output data_t     o_wr_data,
  output logic      o_done_valid,
  output tag_t      o_done_tag,
  output logic      o_done_illegal
);

  localparam int F = `FPU_FLEN;

  data_t w_rs1_box;
  data_t w_rs2_box;
  data_t w_ex2_res;

  logic  r_ex3_valid;
  logic  r_ex3_illegal;

  // ------------------------------------------------------------
  // ex2 compute
  // ------------------------------------------------------------

  // Unboxed singles read as the canonical NaN
  assign w_rs1_box = (&i_rs1[F-1:32]) ? i_rs1 : `FPU_NAN_BOX_S;
  assign w_rs2_box = (&i_rs2[F-1:32]) ? i_rs2 : `FPU_NAN_BOX_S;

  always_comb begin
    case (i_ex2_op)
      OP_FMV_X_W:  w_ex2_res = {{(F-32){i_rs1[31]}}, i_rs1[31:0]};
      OP_FMV_W_X:  w_ex2_res = {{(F-32){1'b1}}, i_rs1[31:0]};
      OP_FMV_X_D,
      OP_FMV_D_X:  w_ex2_res = i_rs1;
      OP_FSGNJ_D:  w_ex2_res = {i_rs2[F-1], i_rs1[F-2:0]};
      OP_FSGNJN_D: w_ex2_res = {~i_rs2[F-1], i_rs1[F-2:0]};
      OP_FSGNJX_D: w_ex2_res = {i_rs1[F-1] ^ i_rs2[F-1], i_rs1[F-2:0]};
      OP_FSGNJ_S: begin
        w_ex2_res = {w_rs1_box[F-1:32], w_rs2_box[31], w_rs1_box[30:0]};
      end
      OP_FSGNJN_S: begin
        w_ex2_res = {w_rs1_box[F-1:32], ~w_rs2_box[31], w_rs1_box[30:0]};
      end
      OP_FSGNJX_S: begin
        w_ex2_res = {w_rs1_box[F-1:32], w_rs1_box[31] ^ w_rs2_box[31], w_rs1_box[30:0]};
      end
      default:     w_ex2_res = '0;
    endcase
  end

  // ------------------------------------------------------------
  // ex3 registers
  // ------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex3_valid <= 1'b0;
    end else begin
      r_ex3_valid <= i_ex2_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex3_illegal <= (i_ex2_op == OP_ILLEGAL);
    o_wr_type     <= i_ex2_rd_type;
    o_wr_rnid     <= i_ex2_rd_rnid;
    o_wr_data     <= w_ex2_res;
    o_done_tag    <= i_ex2_tag;
  end

  // Write and done report
  assign o_wr_valid     = r_ex3_valid & ~r_ex3_illegal;
  assign o_done_valid   = r_ex3_valid;
  assign o_done_illegal = r_ex3_illegal;

endmodule

//--- fpu_move_pipe.sv
// Move and sign-injection pipe, fixed latency 3 with no back-pressure; lane 0 is rs1, lane 1 rs2
`include "fpu_macros.svh"

module fpu_move_pipe
  import fpu_isa_pkg::*;
  import fpu_pipe_pkg::*;
(
  input  logic                         i_clk,
  input  logic                         i_reset_n,
  input  logic                         i_issue_valid,
  input  logic [31:0]                  i_issue_inst,
  input  tag_t                         i_issue_tag,
  input  rnid_t [`FPU_SRC_NUM-1:0]     i_rs_rnid,
  input  rnid_t                        i_rd_rnid,
  input  logic                         i_flush,
  output logic [`FPU_SRC_NUM-1:0]      o_rf_valid,
  output reg_type_e [`FPU_SRC_NUM-1:0] o_rf_type,
  output rnid_t [`FPU_SRC_NUM-1:0]     o_rf_rnid,
  input  data_t [`FPU_SRC_NUM-1:0]     i_rf_gpr_data,
  input  data_t [`FPU_SRC_NUM-1:0]     i_rf_fpr_data,
  input  wb_valid_t                    i_wb_valid,
  input  wb_type_t                     i_wb_type,
  input  wb_rnid_t                     i_wb_rnid,
  input  wb_data_t                     i_wb_data,
  output logic                         o_early_wr_valid,
  output reg_type_e                    o_early_wr_type,
  output rnid_t                        o_early_wr_rnid,
  output logic                         o_wr_valid,
  output reg_type_e                    o_wr_type,
  output rnid_t                        o_wr_rnid,
  output data_t                        o_wr_data,
  output logic                         o_done_valid,
  output tag_t                         o_done_tag,
  output logic                         o_done_illegal
);

  logic                         w_ex0_valid;
  logic [`FPU_SRC_NUM-1:0]      w_ex0_src_use;
  reg_type_e [`FPU_SRC_NUM-1:0] w_ex0_src_type;
  logic                         w_ex2_valid;
  fp_op_e                       w_ex2_op;
  reg_type_e                    w_ex2_rd_type;
  rnid_t                        w_ex2_rd_rnid;
  tag_t                         w_ex2_tag;
  data_t [`FPU_SRC_NUM-1:0]     w_ex2_src_data;

  fpu_issue_stage u_issue (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_issue_valid  (i_issue_valid),
    .i_issue_inst   (i_issue_inst),
    .i_issue_tag    (i_issue_tag),
    .i_rd_rnid      (i_rd_rnid),
    .i_flush        (i_flush),
    .o_ex0_valid    (w_ex0_valid),
    .o_ex0_src_use  (w_ex0_src_use),
    .o_ex0_src_type (w_ex0_src_type),
    .o_ex1_valid    (o_early_wr_valid),
    .o_ex1_rd_type  (o_early_wr_type),
    .o_ex1_rd_rnid  (o_early_wr_rnid),
    .o_ex2_valid    (w_ex2_valid),
    .o_ex2_op       (w_ex2_op),
    .o_ex2_rd_type  (w_ex2_rd_type),
    .o_ex2_rd_rnid  (w_ex2_rd_rnid),
    .o_ex2_tag      (w_ex2_tag)
  );

  for (genvar g = 0; g < `FPU_SRC_NUM; g++) begin : g_lane
    fpu_operand_lane u_lane (
      .i_clk         (i_clk),
      .i_reset_n     (i_reset_n),
      .i_ex0_valid   (w_ex0_valid),
      .i_use         (w_ex0_src_use[g]),
      .i_type        (w_ex0_src_type[g]),
      .i_rnid        (i_rs_rnid[g]),
      .i_wb_valid    (i_wb_valid),
      .i_wb_type     (i_wb_type),
      .i_wb_rnid     (i_wb_rnid),
      .i_wb_data     (i_wb_data),
      .i_rf_gpr_data (i_rf_gpr_data[g]),
      .i_rf_fpr_data (i_rf_fpr_data[g]),
      .o_rf_valid    (o_rf_valid[g]),
      .o_rf_type     (o_rf_type[g]),
      .o_rf_rnid     (o_rf_rnid[g]),
      .o_ex2_data    (w_ex2_src_data[g])
    );
  end

  fpu_result_stage u_result (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_ex2_valid    (w_ex2_valid),
    .i_ex2_op       (w_ex2_op),
    .i_ex2_rd_type  (w_ex2_rd_type),
    .i_ex2_rd_rnid  (w_ex2_rd_rnid),
    .i_ex2_tag      (w_ex2_tag),
    .i_rs1          (w_ex2_src_data[0]),
    .i_rs2          (w_ex2_src_data[1]),
    .o_wr_valid     (o_wr_valid),
    .o_wr_type      (o_wr_type),
    .o_wr_rnid      (o_wr_rnid),
    .o_wr_data      (o_wr_data),
    .o_done_valid   (o_done_valid),
    .o_done_tag     (o_done_tag),
    .o_done_illegal (o_done_illegal)
  );

endmodule

//--- tb_fpu_move_pipe.sv
// Random testbench with fixed seed; the reference model tracks the pipe one stage per cycle
`include "fpu_macros.svh"

module tb_fpu_move_pipe;
  import fpu_isa_pkg::*;
  import fpu_pipe_pkg::*;

  localparam logic [3:0] K_ILLEGAL = 4'd10;

  logic                         i_clk;
  logic                         i_reset_n;
  logic                         i_issue_valid;
  logic [31:0]                  i_issue_inst;
  tag_t                         i_issue_tag;
  rnid_t [`FPU_SRC_NUM-1:0]     i_rs_rnid;
  rnid_t                        i_rd_rnid;
  logic                         i_flush;
  logic [`FPU_SRC_NUM-1:0]      o_rf_valid;
  reg_type_e [`FPU_SRC_NUM-1:0] o_rf_type;
  rnid_t [`FPU_SRC_NUM-1:0]     o_rf_rnid;
  data_t [`FPU_SRC_NUM-1:0]     i_rf_gpr_data;
  data_t [`FPU_SRC_NUM-1:0]     i_rf_fpr_data;
  wb_valid_t                    i_wb_valid;
  wb_type_t                     i_wb_type;
  wb_rnid_t                     i_wb_rnid;
  wb_data_t                     i_wb_data;
  logic                         o_early_wr_valid;
  reg_type_e                    o_early_wr_type;
  rnid_t                        o_early_wr_rnid;
  logic                         o_wr_valid;
  reg_type_e                    o_wr_type;
  rnid_t                        o_wr_rnid;
  data_t                        o_wr_data;
  logic                         o_done_valid;
  tag_t                         o_done_tag;
  logic                         o_done_illegal;

  logic [31:0] seed;
  int          errors;
  int          other_errors;
  int          op_seen [0:10];
  data_t       gpr_arr [0:63];
  data_t       fpr_arr [0:63];
  rnid_t       wb_ctr;
  logic [3:0]  cur_k;

  // Reference pipe, one register set per stage
  logic        m1_v, m2_v, m3_v, m3_ill;
  logic [3:0]  m1_k, m2_k, m3_k;
  tag_t        m1_tag, m2_tag, m3_tag;
  rnid_t       m1_rd, m2_rd, m3_rd, m1_s0, m2_s0, m1_s1, m2_s1;
  logic        m3_rdt;
  data_t       m3_data;

  fpu_move_pipe u_dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function logic [31:0] next_rand();
    seed = xorshift(seed);
    return seed;
  endfunction

  function data_t rand_data();
    data_t d;
    d = {next_rand(), next_rand()};
    if (d[5]) d[63:32] = '1;
    return d;
  endfunction

  function automatic logic [31:0] encode_inst(input logic [3:0] k, input logic alt);
    logic [6:0] f7;
    logic [2:0] f3;
    logic [4:0] rs2;
    f7  = 7'h10;
    f3  = 3'b000;
    rs2 = 5'd2;
    case (k)
      4'd0: begin
        f7  = 7'h70;
        rs2 = 5'd0;
      end
      4'd1: begin
        f7  = 7'h78;
        rs2 = 5'd0;
      end
      4'd2: begin
        f7  = 7'h71;
        rs2 = 5'd0;
      end
      4'd3: begin
        f7  = 7'h79;
        rs2 = 5'd0;
      end
      4'd4, 4'd5, 4'd6: f3 = 3'(k - 4'd4);
      4'd7, 4'd8, 4'd9: begin
        f7 = 7'h11;
        f3 = 3'(k - 4'd7);
      end
      default: begin
        if (alt) f7 = 7'h78;
        else f3 = 3'b011;
      end
    endcase
    return {f7, rs2, 5'd1, f3, 5'd4, 7'b101_0011};
  endfunction

  function automatic logic rd_is_gpr(input logic [3:0] k);
    return (k == 4'd0) || (k == 4'd2);
  endfunction

  function automatic logic src_is_gpr(input logic [3:0] k);
    return (k == 4'd1) || (k == 4'd3);
  endfunction

  // Read requests expected in ex0, x0 is never read
  function automatic logic [`FPU_SRC_NUM-1:0] rf_req_mask(input logic v, input logic [3:0] k,
                                                          input rnid_t id0);
    logic [`FPU_SRC_NUM-1:0] m;
    m = '0;
    if (v && (k != K_ILLEGAL)) begin
      m[0] = !(src_is_gpr(k) && (id0 == '0));
      m[1] = (k >= 4'd4);
    end
    return m;
  endfunction

  function automatic data_t box_s(input data_t x);
    return (&x[63:32]) ? x : `FPU_NAN_BOX_S;
  endfunction

  // Operand as the pipe should see it at the end of ex2
  function data_t src_val(input logic is_gpr, input rnid_t id);
    data_t v;
    v = is_gpr ? gpr_arr[id] : fpr_arr[id];
    for (int p = 0; p < `FPU_WB_PORTS; p++) begin
      if (i_wb_valid[p] && (i_wb_type[p] == reg_type_e'(~is_gpr)) && (i_wb_rnid[p] == id)) begin
        v = i_wb_data[p];
      end
    end
    if (is_gpr && (id == '0)) v = '0;
    return v;
  endfunction

  function automatic data_t ref_result(input logic [3:0] k, input data_t a, input data_t b);
    data_t ab;
    data_t bb;
    ab = box_s(a);
    bb = box_s(b);
    case (k)
      4'd0: return {{32{a[31]}}, a[31:0]};
      4'd1: return {32'hffff_ffff, a[31:0]};
      4'd2, 4'd3: return a;
      4'd4: return {ab[63:32], bb[31], ab[30:0]};
      4'd5: return {ab[63:32], ~bb[31], ab[30:0]};
      4'd6: return {ab[63:32], ab[31] ^ bb[31], ab[30:0]};
      4'd7: return {b[63], a[62:0]};
      4'd8: return {~b[63], a[62:0]};
      4'd9: return {a[63] ^ b[63], a[62:0]};
      default: return '0;
    endcase
  endfunction

  function rnid_t pick_src();
    logic [31:0] r;
    r = next_rand();
    if (r[2:0] == 3'd0) return '0;
    return wb_ctr + rnid_t'(r[4:3]);
  endfunction

  // ------------------------------------------------------------
  // Register file and reference model
  // ------------------------------------------------------------
  always @(posedge i_clk) begin
    for (int g = 0; g < `FPU_SRC_NUM; g++) begin
      if (o_rf_valid[g]) begin
        i_rf_gpr_data[g] <= gpr_arr[o_rf_rnid[g]];
        i_rf_fpr_data[g] <= fpr_arr[o_rf_rnid[g]];
      end
    end
  end

  always @(posedge i_clk) begin
    if (!i_reset_n) begin
      m1_v <= 1'b0;
      m2_v <= 1'b0;
      m3_v <= 1'b0;
    end else begin
      m1_v   <= i_issue_valid & ~i_flush;
      m1_k   <= cur_k;
      m1_tag <= i_issue_tag;
      m1_rd  <= i_rd_rnid;
      m1_s0  <= i_rs_rnid[0];
      m1_s1  <= i_rs_rnid[1];
      m2_v   <= m1_v & ~i_flush;
      m2_k   <= m1_k;
      m2_tag <= m1_tag;
      m2_rd  <= m1_rd;
      m2_s0  <= m1_s0;
      m2_s1  <= m1_s1;
      m3_v   <= m2_v & ~i_flush;
      m3_k   <= m2_k;
      m3_ill <= (m2_k == K_ILLEGAL);
      m3_tag <= m2_tag;
      m3_rd  <= m2_rd;
      m3_rdt <= ~rd_is_gpr(m2_k);
      m3_data <= ref_result(m2_k, src_val(src_is_gpr(m2_k), m2_s0), src_val(1'b0, m2_s1));
      if (m3_v) op_seen[m3_k] <= op_seen[m3_k] + 1;
      for (int p = 0; p < `FPU_WB_PORTS; p++) begin
        if (i_wb_valid[p] && (i_wb_type[p] == REG_GPR)) gpr_arr[i_wb_rnid[p]] <= i_wb_data[p];
        if (i_wb_valid[p] && (i_wb_type[p] == REG_FPR)) fpr_arr[i_wb_rnid[p]] <= i_wb_data[p];
      end
    end
  end

  // ------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------
  a_done: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_done_valid == m3_v) && (!o_done_valid || (o_done_illegal == m3_ill &&
                                                 o_done_tag == m3_tag)))
    else begin
      errors++;
      $display("CHECK FAILED t=%0t: done report mismatch", $time);
    end

  a_wr: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_wr_valid == (m3_v && !m3_ill)) && (!o_wr_valid || (o_wr_data == m3_data &&
     o_wr_rnid == m3_rd && o_wr_type == reg_type_e'(m3_rdt))))
    else begin
      errors++;
      $display("CHECK FAILED t=%0t: write mismatch", $time);
    end

  a_early: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_early_wr_valid == (m1_v && (m1_k != K_ILLEGAL) && !i_flush)) &&
    (!o_early_wr_valid || (o_early_wr_rnid == m1_rd &&
                           o_early_wr_type == reg_type_e'(~rd_is_gpr(m1_k)))))
    else begin
      errors++;
      $display("CHECK FAILED t=%0t: early wakeup mismatch", $time);
    end

  a_rf_req: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    (o_rf_valid == rf_req_mask(i_issue_valid && !i_flush, cur_k, i_rs_rnid[0])) &&
    (!o_rf_valid[0] || (o_rf_rnid[0] == i_rs_rnid[0] &&
                        o_rf_type[0] == reg_type_e'(!src_is_gpr(cur_k)))) &&
    (!o_rf_valid[1] || (o_rf_rnid[1] == i_rs_rnid[1] && o_rf_type[1] == REG_FPR)))
    else begin
      errors++;
      $display("CHECK FAILED t=%0t: register-file read request mismatch", $time);
    end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  initial begin
    logic [31:0] r;
    logic [3:0]  k;
    int          p;
    int          n;
    seed = 32'hc6e8_b206;
    errors = 0;
    other_errors = 0;
    wb_ctr = '0;
    cur_k = K_ILLEGAL;
    for (int i = 0; i <= 10; i++) op_seen[i] = 0;
    for (int a = 0; a < 64; a++) begin
      gpr_arr[a] = rand_data() ^ {58'd0, 6'(a)};
      fpr_arr[a] = rand_data() ^ {6'(a), 58'd0};
    end
    i_reset_n = 1'b0;
    i_issue_valid = 1'b0;
    i_issue_inst = '0;
    i_issue_tag = '0;
    i_rs_rnid = '0;
    i_rd_rnid = '0;
    i_flush = 1'b0;
    i_rf_gpr_data = '0;
    i_rf_fpr_data = '0;
    i_wb_valid = '0;
    i_wb_type = '0;
    i_wb_rnid = '0;
    i_wb_data = '0;
    repeat (5) @(posedge i_clk);
    i_reset_n <= 1'b1;
    // Idle stretch, outputs must stay low
    repeat (8) @(posedge i_clk);
    for (int c = 0; c < 800; c++) begin
      @(posedge i_clk);
      r = next_rand();
      k = 4'(next_rand() % 32'd11);
      i_issue_valid <= (r[1:0] != 2'd0);
      i_issue_inst  <= encode_inst(k, r[8]);
      cur_k         <= k;
      i_issue_tag   <= i_issue_tag + tag_t'(1);
      i_rs_rnid[0]  <= pick_src();
      i_rs_rnid[1]  <= pick_src();
      i_rd_rnid     <= rnid_t'(r[21:16]);
      i_flush       <= (r[15:12] == 4'd0);
      i_wb_valid    <= '0;
      p = int'(r[11:10]) % 3;
      if (r[9]) begin
        i_wb_valid[p] <= 1'b1;
        i_wb_type[p]  <= reg_type_e'(r[22]);
        i_wb_rnid[p]  <= wb_ctr;
        i_wb_data[p]  <= rand_data();
        wb_ctr = wb_ctr + rnid_t'(1);
      end else if (r[23]) begin
        // Bus traffic on x0, which must never be forwarded
        i_wb_valid[p] <= 1'b1;
        i_wb_type[p]  <= REG_GPR;
        i_wb_rnid[p]  <= '0;
        i_wb_data[p]  <= rand_data();
      end
    end
    @(posedge i_clk);
    i_issue_valid <= 1'b0;
    i_wb_valid    <= '0;
    i_flush       <= 1'b0;
    n = 0;
    @(posedge i_clk);
    while ((m1_v || m2_v || m3_v) && (n < 50)) begin
      @(posedge i_clk);
      n++;
    end
    if (n >= 50) begin
      $display("Timeout: pipe did not drain");
      $display("** FAIL **");
      $finish;
    end else begin
      for (int i = 0; i <= 10; i++) begin
        if (op_seen[i] == 0) begin
          other_errors++;
          $display("Op %0d never completed during the run", i);
        end
      end
      $display("Errors: %0d failed checks, %0d other errors", errors, other_errors);
      if ((errors == 0) && (other_errors == 0)) begin
        $display("** PASS **");
      end else begin
        $display("** FAIL **");
      end
      $finish;
    end
  end

endmodule

//--- verilog.f
+incdir+.
fpu_isa_pkg.sv
fpu_pipe_pkg.sv
fpu_issue_stage.sv
fpu_operand_lane.sv
fpu_result_stage.sv
fpu_move_pipe.sv
tb_fpu_move_pipe.sv

//--- run.sh
#!/bin/sh
# Build and run with Verilator, then judge the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f verilog.f --top-module tb_fpu_move_pipe -o sim \
  > build.log 2>&1 &&
./obj_dir/sim > sim.log 2>&1 &&
! grep -q '\*\* FAIL \*\*' sim.log &&
grep -q '\*\* PASS \*\*' sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }
